/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_exec_stage
FILELIST = exec_stage_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* exec_stage_top.f */
source/exec_isa_pkg.sv
source/exec_mem_pkg.sv
source/bit_count_timer.sv
source/alu_result_unit.sv
source/mem_access_unit.sv
source/exec_ctrl_fsm.sv
source/exec_stage_top.sv
verif/tb_exec_stage.sv

/* source/alu_result_unit.sv */
`timescale 1ns/100ps

module alu_result_unit import exec_isa_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int CNT_W  = 6
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  exec_op_e              op_i,
    input  logic [INST_W-1:0]     inst_i,
    input  logic [DATA_W-1:0]     rs_data_i,
    input  logic [DATA_W-1:0]     rt_data_i,
    input  logic [CNT_W-1:0]      count_i,
    input  logic                  advance_i,
    input  logic                  exc_i,
    output logic                  overflow_o,
    output logic [DATA_W-1:0]     eaddr_o,
    output logic                  valid_o,
    output logic [DATA_W-1:0]     result_o,
    output logic [REG_ADDR_W-1:0] waddr_o
);

    localparam int SH_W = $clog2(DATA_W);

    logic [IMM_W-1:0]      imm;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W-1:0]     op_b;
    logic [DATA_W-1:0]     sum;
    logic [DATA_W-1:0]     diff;
    logic [DATA_W-1:0]     alu_res;
    logic [SH_W-1:0]       shamt;
    logic                  imm_zx;
    logic                  use_imm;
    logic                  ovf_add;
    logic                  ovf_sub;
    logic [REG_ADDR_W-1:0] waddr;

    assign imm     = inst_i[IMM_W-1:0];
    assign imm_zx  = op_i inside {OP_ANDI, OP_ORI, OP_XORI};
    assign imm_ext = imm_zx ? {{(DATA_W-IMM_W){1'b0}}, imm}
                            : {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
    assign use_imm = (op_i inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                   OP_ANDI, OP_ORI, OP_XORI})
                  || is_load_op(op_i) || is_store_op(op_i);
    assign op_b    = use_imm ? imm_ext : rt_data_i;

    // fixed shifts take sa, variable shifts take rs
    assign shamt = (op_i inside {OP_SLL, OP_SRL, OP_SRA}) ?
                   SH_W'(inst_i[SA_LSB +: REG_ADDR_W]) : rs_data_i[SH_W-1:0];

    assign sum  = rs_data_i + op_b;
    assign diff = rs_data_i - op_b;

    assign ovf_add = (rs_data_i[DATA_W-1] == op_b[DATA_W-1])
                  && (sum[DATA_W-1] != rs_data_i[DATA_W-1]);
    assign ovf_sub = (rs_data_i[DATA_W-1] != op_b[DATA_W-1])
                  && (diff[DATA_W-1] != rs_data_i[DATA_W-1]);

    assign overflow_o = ((op_i == OP_ADD || op_i == OP_ADDI) && ovf_add)
                     || (op_i == OP_SUB && ovf_sub);

    // loads and stores use the imm adder path
    assign eaddr_o = sum;

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU: alu_res = sum;
            OP_SUB, OP_SUBU:                    alu_res = diff;
            OP_AND, OP_ANDI:                    alu_res = rs_data_i & op_b;
            OP_OR, OP_ORI:                      alu_res = rs_data_i | op_b;
            OP_XOR, OP_XORI:                    alu_res = rs_data_i ^ op_b;
            OP_NOR:                             alu_res = ~(rs_data_i | op_b);
            OP_SLT, OP_SLTI:  alu_res = DATA_W'($signed(rs_data_i) < $signed(op_b));
            OP_SLTU, OP_SLTIU:                  alu_res = DATA_W'(rs_data_i < op_b);
            OP_SLL, OP_SLLV:                    alu_res = rt_data_i << shamt;
            OP_SRL, OP_SRLV:                    alu_res = rt_data_i >> shamt;
            OP_SRA, OP_SRAV:                    alu_res = $signed(rt_data_i) >>> shamt;
            OP_LUI:                             alu_res = {imm, {(DATA_W-IMM_W){1'b0}}};
            OP_CLZ, OP_CLO:                     alu_res = DATA_W'(count_i);
            default:                            alu_res = sum;
        endcase
    end

    always_comb begin
        if (use_imm && !is_store_op(op_i) || op_i == OP_LUI) begin
            waddr = inst_i[RT_LSB +: REG_ADDR_W];
        end else if (is_store_op(op_i) || op_i == OP_NOP) begin
            waddr = '0;
        end else begin
            waddr = inst_i[RD_LSB +: REG_ADDR_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= advance_i && !exc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            result_o <= alu_res;
            waddr_o  <= waddr;
        end
    end

endmodule

/* source/bit_count_timer.sv */
`timescale 1ns/100ps

module bit_count_timer #(
    parameter int DATA_W = 32,
    parameter int CNT_W  = 6
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start_i,
    input  logic              count_ones_i,
    input  logic [DATA_W-1:0] operand_i,
    input  logic              hold_i,
    output logic [CNT_W-1:0]  count_o,
    output logic              done_o
);

    logic              busy;
    logic              at_end;
    logic [DATA_W-1:0] shift_q;

    // stop on first cleared bit or after a full word
    assign at_end = !shift_q[DATA_W-1] || (count_o == CNT_W'(DATA_W));
    assign done_o = busy && at_end;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
        end else if (start_i) begin
            busy <= 1'b1;
        end else if (done_o && !hold_i) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            // clz counts leading ones of the inverse
            shift_q <= count_ones_i ? operand_i : ~operand_i;
            count_o <= '0;
        end else if (busy && !at_end) begin
            shift_q <= shift_q << 1;
            count_o <= count_o + 1'b1;
        end
    end

    // finished count waits unchanged for downstream
    a_count_held: assert property (
        @(posedge clk) disable iff (!resetn)
        done_o && hold_i |=> $stable(count_o)
    );

endmodule

/* source/exec_ctrl_fsm.sv */
`timescale 1ns/100ps

module exec_ctrl_fsm import exec_isa_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid_i,
    input  exec_op_e  op_i,
    input  logic      ready_i,
    input  logic      data_addr_ok_i,
    input  logic      overflow_i,
    input  exc_code_e addr_err_i,
    input  logic      count_done_i,
    output logic      count_start_o,
    output logic      advance_o,
    output logic      done_o,
    output logic      data_req_o,
    output logic      commit_o,
    output exc_code_e commit_code_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_COUNT,
        S_MEM,
        S_HOLD
    } state_e;

    state_e state;
    state_e state_next;
    logic   mem_op;
    logic   exc;

    assign mem_op = is_load_op(op_i) || is_store_op(op_i);
    assign exc    = overflow_i || (addr_err_i != EXC_NONE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        done_o        = 1'b0;
        data_req_o    = 1'b0;
        count_start_o = 1'b0;
        case (state)
            S_IDLE: begin
                if (valid_i) begin
                    if (is_count_op(op_i)) begin
                        count_start_o = 1'b1;
                        state_next    = S_COUNT;
                    end else if (mem_op && addr_err_i == EXC_NONE) begin
                        // request goes out in the first cycle
                        data_req_o = 1'b1;
                        done_o     = data_addr_ok_i;
                        if (!data_addr_ok_i) begin
                            state_next = S_MEM;
                        end else if (!ready_i) begin
                            state_next = S_HOLD;
                        end
                    end else begin
                        // alu ops and misaligned accesses finish at once
                        done_o = 1'b1;
                    end
                end
            end
            S_COUNT: begin
                done_o = count_done_i;
                if (count_done_i && ready_i) begin
                    state_next = S_IDLE;
                end
            end
            S_MEM: begin
                data_req_o = 1'b1;
                done_o     = data_addr_ok_i;
                if (data_addr_ok_i) begin
                    state_next = ready_i ? S_IDLE : S_HOLD;
                end
            end
            S_HOLD: begin
                // address taken, waiting on downstream
                done_o = 1'b1;
                if (ready_i) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    assign advance_o     = done_o && ready_i;
    assign commit_o      = advance_o && exc;
    assign commit_code_o = overflow_i ? EXC_OV : addr_err_i;

    // misaligned address must never reach the memory side
    a_no_req_on_addr_err: assert property (
        @(posedge clk) disable iff (!resetn)
        data_req_o |-> addr_err_i == EXC_NONE
    );

endmodule

/* source/exec_isa_pkg.sv */
package exec_isa_pkg;

    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    // instruction field positions
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    localparam int SA_LSB = 6;
    localparam int IMM_W  = 16;

    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_CLZ, OP_CLO,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } exec_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12
    } exc_code_e;

    function automatic logic is_count_op(exec_op_e op);
        return op inside {OP_CLZ, OP_CLO};
    endfunction

    function automatic logic is_load_op(exec_op_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store_op(exec_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage

/* source/exec_mem_pkg.sv */
package exec_mem_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // one strobe bit per byte lane
    localparam int STRB_W = 4;

    // kseg0 and kseg1 share the top two address bits
    localparam logic [1:0] UNMAPPED_SEG_HI = 2'b10;

    // unmapped translation drops the segment bits
    localparam int XLATE_CLEAR_W = 3;

endpackage

/* source/exec_stage_top.sv */
`timescale 1ns/100ps

module exec_stage_top import exec_isa_pkg::*, exec_mem_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  valid_i,
    input  exec_op_e              op_i,
    input  logic [INST_W-1:0]     inst_i,
    input  logic [DATA_W-1:0]     rs_data_i,
    input  logic [DATA_W-1:0]     rt_data_i,
    input  logic                  ready_i,
    input  logic                  data_addr_ok_i,
    output logic                  done_o,
    output logic                  valid_o,
    output logic [DATA_W-1:0]     result_o,
    output logic [REG_ADDR_W-1:0] waddr_o,
    output logic                  data_req_o,
    output logic                  data_wr_o,
    output mem_size_e             data_size_o,
    output logic [DATA_W-1:0]     data_addr_o,
    output logic [STRB_W-1:0]     data_wstrb_o,
    output logic [DATA_W-1:0]     data_wdata_o,
    output logic                  commit_o,
    output exc_code_e             commit_code_o,
    output logic [DATA_W-1:0]     commit_bvaddr_o
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    logic              count_start;
    logic              count_done;
    logic [CNT_W-1:0]  count;
    logic              advance;
    logic              overflow;
    logic [DATA_W-1:0] eaddr;
    exc_code_e         addr_err;

    exec_ctrl_fsm exec_ctrl_fsm_i (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .ready_i        (ready_i),
        .data_addr_ok_i (data_addr_ok_i),
        .overflow_i     (overflow),
        .addr_err_i     (addr_err),
        .count_done_i   (count_done),
        .count_start_o  (count_start),
        .advance_o      (advance),
        .done_o         (done_o),
        .data_req_o     (data_req_o),
        .commit_o       (commit_o),
        .commit_code_o  (commit_code_o)
    );

    bit_count_timer #(
        .DATA_W (DATA_W),
        .CNT_W  (CNT_W)
    ) bit_count_timer_i (
        .clk          (clk),
        .resetn       (resetn),
        .start_i      (count_start),
        .count_ones_i (op_i == OP_CLO),
        .operand_i    (rs_data_i),
        .hold_i       (!ready_i),
        .count_o      (count),
        .done_o       (count_done)
    );

    alu_result_unit #(
        .DATA_W (DATA_W),
        .CNT_W  (CNT_W)
    ) alu_result_unit_i (
        .clk        (clk),
        .resetn     (resetn),
        .op_i       (op_i),
        .inst_i     (inst_i),
        .rs_data_i  (rs_data_i),
        .rt_data_i  (rt_data_i),
        .count_i    (count),
        .advance_i  (advance),
        .exc_i      (commit_o),
        .overflow_o (overflow),
        .eaddr_o    (eaddr),
        .valid_o    (valid_o),
        .result_o   (result_o),
        .waddr_o    (waddr_o)
    );

    mem_access_unit #(
        .DATA_W (DATA_W)
    ) mem_access_unit_i (
        .op_i         (op_i),
        .eaddr_i      (eaddr),
        .rt_data_i    (rt_data_i),
        .addr_err_o   (addr_err),
        .data_addr_o  (data_addr_o),
        .data_wr_o    (data_wr_o),
        .data_size_o  (data_size_o),
        .data_wstrb_o (data_wstrb_o),
        .data_wdata_o (data_wdata_o),
        .bvaddr_o     (commit_bvaddr_o)
    );

endmodule

/* source/mem_access_unit.sv */
`timescale 1ns/100ps

module mem_access_unit import exec_isa_pkg::*, exec_mem_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  exec_op_e          op_i,
    input  logic [DATA_W-1:0] eaddr_i,
    input  logic [DATA_W-1:0] rt_data_i,
    output exc_code_e         addr_err_o,
    output logic [DATA_W-1:0] data_addr_o,
    output logic              data_wr_o,
    output mem_size_e         data_size_o,
    output logic [STRB_W-1:0] data_wstrb_o,
    output logic [DATA_W-1:0] data_wdata_o,
    output logic [DATA_W-1:0] bvaddr_o
);

    logic [1:0]        offset;
    logic [DATA_W-1:0] ea_aligned;
    logic              misaligned;

    assign offset     = eaddr_i[1:0];
    assign ea_aligned = {eaddr_i[DATA_W-1:2], 2'b00};

    always_comb begin
        case (op_i)
            OP_LB, OP_LBU, OP_SB: data_size_o = SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: data_size_o = SIZE_HALF;
            default:              data_size_o = SIZE_WORD;
        endcase
    end

    assign misaligned = (data_size_o == SIZE_HALF && offset[0])
                     || (data_size_o == SIZE_WORD && offset != 2'b00);

    always_comb begin
        addr_err_o = EXC_NONE;
        if (misaligned && is_load_op(op_i)) begin
            addr_err_o = EXC_ADEL;
        end else if (misaligned && is_store_op(op_i)) begin
            addr_err_o = EXC_ADES;
        end
    end

    // kseg0/kseg1 map straight to physical, everything else passes
    assign data_addr_o = (ea_aligned[DATA_W-1 -: 2] == UNMAPPED_SEG_HI) ?
                         {{XLATE_CLEAR_W{1'b0}}, ea_aligned[DATA_W-XLATE_CLEAR_W-1:0]} :
                         ea_aligned;

    assign data_wr_o = is_store_op(op_i);
    assign bvaddr_o  = eaddr_i;

    always_comb begin
        data_wstrb_o = '0;
        data_wdata_o = rt_data_i;
        if (is_store_op(op_i)) begin
            case (data_size_o)
                SIZE_BYTE: begin
                    data_wstrb_o = STRB_W'(1) << offset;
                    data_wdata_o = {(DATA_W/8){rt_data_i[7:0]}};
                end
                SIZE_HALF: begin
                    data_wstrb_o = STRB_W'(3) << offset;
                    data_wdata_o = {(DATA_W/16){rt_data_i[15:0]}};
                end
                default: begin
                    data_wstrb_o = '1;
                end
            endcase
        end
        // aligned stores write one lane per byte of the access
        assert (!(is_store_op(op_i) && addr_err_o == EXC_NONE)
                || $countones(data_wstrb_o) == (1 << data_size_o));
    end

endmodule

/* verif/exec_stimulus.txt */
# op inst rs rt | expected: result waddr code addr strb wdata size (all hex)
# addr is the translated address for memory ops, the bad address on an address error
01 00001800 00000005 00000007 0000000c 03 00 00000000 0 00000000 0
03 00002000 00000010 00000020 fffffff0 04 00 00000000 0 00000000 0
09 00003000 fffffffe 00000001 00000001 06 00 00000000 0 00000000 0
0d 00003900 00000000 80000000 f8000000 07 00 00000000 0 00000000 0
0e 00001000 00000024 0000000f 000000f0 02 00 00000000 0 00000000 0
11 0008fffc 00000010 00000000 0000000c 08 00 00000000 0 00000000 0
16 00098001 12340000 00000000 12348001 09 00 00000000 0 00000000 0
18 000abeef 00000000 00000000 beef0000 0a 00 00000000 0 00000000 0
01 00001800 7fffffff 00000001 00000000 00 0c 00000000 0 00000000 0
11 00080001 7fffffff 00000000 00000000 00 0c 00000000 0 00000000 0
03 00002000 80000000 00000001 00000000 00 0c 00000000 0 00000000 0
19 00005800 00010000 00000000 0000000f 0b 00 00000000 0 00000000 0
1a 00006000 ff000000 00000000 00000008 0c 00 00000000 0 00000000 0
19 00006800 00000000 00000000 00000020 0d 00 00000000 0 00000000 0
1f 000e0008 80001000 00000000 80001008 0e 00 00001008 0 00000000 2
1c 000f0003 a0000100 00000000 a0000103 0f 00 00000100 0 00000000 0
21 00100002 00400000 1234abcd 00400002 00 00 00400000 c abcdabcd 1
20 00000001 c0000010 00000055 c0000011 00 00 c0000010 2 55555555 0
22 00000004 10000000 deadbeef 10000004 00 00 10000004 f deadbeef 2
1d 00010001 10000000 00000000 00000000 00 04 10000001 0 00000000 1
1f 00010002 20000000 00000000 00000000 00 04 20000002 0 00000000 2
21 00000003 30000000 00000000 00000000 00 05 30000003 0 00000000 1
22 00000001 40000000 00000000 00000000 00 05 40000001 0 00000000 2

/* verif/tb_exec_stage.sv */
`timescale 1ns/100ps

module tb_exec_stage import exec_isa_pkg::*, exec_mem_pkg::*; ();

    localparam int    DATA_W           = 32;
    localparam int    CLK_PERIOD       = 100;
    localparam int    MAX_ENTRIES      = 64;
    localparam int    CYCLES_PER_ENTRY = 40;
    localparam string STIM_FILE        = "verif/exec_stimulus.txt";

    // stimulus columns
    localparam int COL_OP    = 0;
    localparam int COL_INST  = 1;
    localparam int COL_RS    = 2;
    localparam int COL_RT    = 3;
    localparam int COL_RES   = 4;
    localparam int COL_WADDR = 5;
    localparam int COL_CODE  = 6;
    localparam int COL_ADDR  = 7;
    localparam int COL_STRB  = 8;
    localparam int COL_WDATA = 9;
    localparam int COL_SIZE  = 10;
    localparam int NUM_COLS  = 11;

    logic                  clk;
    logic                  resetn;
    logic                  valid_i;
    exec_op_e              op_i;
    logic [INST_W-1:0]     inst_i;
    logic [DATA_W-1:0]     rs_data_i;
    logic [DATA_W-1:0]     rt_data_i;
    logic                  ready_i;
    logic                  data_addr_ok_i;
    logic                  done_o;
    logic                  valid_o;
    logic [DATA_W-1:0]     result_o;
    logic [REG_ADDR_W-1:0] waddr_o;
    logic                  data_req_o;
    logic                  data_wr_o;
    mem_size_e             data_size_o;
    logic [DATA_W-1:0]     data_addr_o;
    logic [STRB_W-1:0]     data_wstrb_o;
    logic [DATA_W-1:0]     data_wdata_o;
    logic                  commit_o;
    exc_code_e             commit_code_o;
    logic [DATA_W-1:0]     commit_bvaddr_o;

    logic [31:0] stim [0:MAX_ENTRIES-1][0:NUM_COLS-1];
    logic [31:0] lfsr_state;
    int          n_entries;
    int          errors;
    int          cycle_count;
    int          cycle_limit;

    exec_stage_top #(
        .DATA_W (DATA_W)
    ) exec_stage_top_i (
        .clk             (clk),
        .resetn          (resetn),
        .valid_i         (valid_i),
        .op_i            (op_i),
        .inst_i          (inst_i),
        .rs_data_i       (rs_data_i),
        .rt_data_i       (rt_data_i),
        .ready_i         (ready_i),
        .data_addr_ok_i  (data_addr_ok_i),
        .done_o          (done_o),
        .valid_o         (valid_o),
        .result_o        (result_o),
        .waddr_o         (waddr_o),
        .data_req_o      (data_req_o),
        .data_wr_o       (data_wr_o),
        .data_size_o     (data_size_o),
        .data_addr_o     (data_addr_o),
        .data_wstrb_o    (data_wstrb_o),
        .data_wdata_o    (data_wdata_o),
        .commit_o        (commit_o),
        .commit_code_o   (commit_code_o),
        .commit_bvaddr_o (commit_bvaddr_o)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERR at %0d ns: %s", $time, msg);
    endtask

    task automatic load_stimulus();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                  stim[n_entries][0], stim[n_entries][1], stim[n_entries][2],
                                  stim[n_entries][3], stim[n_entries][4], stim[n_entries][5],
                                  stim[n_entries][6], stim[n_entries][7], stim[n_entries][8],
                                  stim[n_entries][9], stim[n_entries][10]);
                    if (cnt == NUM_COLS) begin
                        n_entries++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the advance
    task automatic run_entry(input int i);
        exec_op_e    op;
        logic [4:0]  code;
        logic        mem_op;
        logic        store_op;
        logic        exp_req;
        logic        acked;
        logic        adv;
        logic [31:0] held_result;
        int          ok_delay;
        int          stall;
        int          done_cnt;
        int          done_cyc;
        int          cyc;
        op       = exec_op_e'(stim[i][COL_OP][5:0]);
        code     = stim[i][COL_CODE][4:0];
        mem_op   = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
        store_op = op inside {OP_SB, OP_SH, OP_SW};
        take_bits(2, ok_delay);
        take_bits(2, stall);
        if (op inside {OP_CLZ, OP_CLO}) begin
            done_cyc = int'(stim[i][COL_RES]) + 1;
        end else if (mem_op && code == 0) begin
            done_cyc = ok_delay;
        end else begin
            done_cyc = 0;
        end
        cyc         = 0;
        done_cnt    = 0;
        acked       = 1'b0;
        adv         = 1'b0;
        held_result = result_o;
        valid_i     = 1'b1;
        op_i        = op;
        inst_i      = stim[i][COL_INST];
        rs_data_i   = stim[i][COL_RS];
        rt_data_i   = stim[i][COL_RT];
        while (!adv) begin
            data_addr_ok_i = mem_op && (cyc == ok_delay);
            ready_i        = (done_cnt >= stall);
            @(posedge clk);
            exp_req = mem_op && code == 0 && !acked;
            if (data_req_o !== exp_req) begin
                report_error($sformatf("entry %0d: data_req_o %b, expected %b",
                                       i, data_req_o, exp_req));
            end
            if (data_req_o) begin
                if (data_addr_o !== stim[i][COL_ADDR]) begin
                    report_error($sformatf("entry %0d: data_addr_o %h, expected %h",
                                           i, data_addr_o, stim[i][COL_ADDR]));
                end
                if (data_size_o !== stim[i][COL_SIZE][1:0] || data_wr_o !== store_op) begin
                    report_error($sformatf("entry %0d: size %0d wr %b, expected size %0d wr %b",
                                           i, data_size_o, data_wr_o, stim[i][COL_SIZE], store_op));
                end
                if (data_wstrb_o !== stim[i][COL_STRB][STRB_W-1:0]) begin
                    report_error($sformatf("entry %0d: data_wstrb_o %h, expected %h",
                                           i, data_wstrb_o, stim[i][COL_STRB]));
                end
                if (store_op && data_wdata_o !== stim[i][COL_WDATA]) begin
                    report_error($sformatf("entry %0d: data_wdata_o %h, expected %h",
                                           i, data_wdata_o, stim[i][COL_WDATA]));
                end
                acked = data_addr_ok_i;
            end
            if (done_cnt == 0 && done_o !== (cyc == done_cyc)) begin
                report_error($sformatf("entry %0d: done_o %b at cycle %0d, expected rise at %0d",
                                       i, done_o, cyc, done_cyc));
            end
            if (done_cnt > 0 && !done_o) begin
                report_error($sformatf("entry %0d: done_o fell while ready_i was low", i));
            end
            if ((cyc > 0 && valid_o) || result_o !== held_result) begin
                report_error($sformatf("entry %0d: output register moved before advance", i));
            end
            adv = done_o && ready_i;
            if (commit_o !== (adv && code != 0)) begin
                report_error($sformatf("entry %0d: commit_o %b at cycle %0d", i, commit_o, cyc));
            end
            if (adv && code != 0) begin
                if (commit_code_o !== code) begin
                    report_error($sformatf("entry %0d: commit_code_o %0d, expected %0d",
                                           i, commit_code_o, code));
                end
                if (code != EXC_OV && commit_bvaddr_o !== stim[i][COL_ADDR]) begin
                    report_error($sformatf("entry %0d: commit_bvaddr_o %h, expected %h",
                                           i, commit_bvaddr_o, stim[i][COL_ADDR]));
                end
            end
            if (done_o) begin
                done_cnt++;
            end
            cyc++;
            @(negedge clk);
        end
        valid_i        = 1'b0;
        data_addr_ok_i = 1'b0;
        if (valid_o !== (code == 0)) begin
            report_error($sformatf("entry %0d: valid_o %b after advance", i, valid_o));
        end
        if (code == 0 && (result_o !== stim[i][COL_RES]
                          || waddr_o !== stim[i][COL_WADDR][4:0])) begin
            report_error($sformatf("entry %0d: result %h waddr %0d, expected %h waddr %0d",
                                   i, result_o, waddr_o, stim[i][COL_RES], stim[i][COL_WADDR]));
        end
    endtask

    initial begin
        clk            = 1'b0;
        resetn         = 1'b0;
        valid_i        = 1'b0;
        op_i           = OP_NOP;
        inst_i         = '0;
        rs_data_i      = '0;
        rt_data_i      = '0;
        ready_i        = 1'b0;
        data_addr_ok_i = 1'b0;
        lfsr_state     = 32'h068c06d2;
        n_entries      = 0;
        errors         = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        load_stimulus();
        cycle_limit = n_entries * CYCLES_PER_ENTRY;
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        @(posedge clk);
        if (valid_o || done_o || data_req_o || commit_o) begin
            report_error("outputs not idle after reset");
        end
        @(negedge clk);
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("entries run: %0d, errors: %0d", n_entries, errors);
        if (errors == 0 && n_entries > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
